// ==== Makefile ====
# Verilator build for the serial configuration loader testbench

VERILATOR ?= verilator
TOP       ?= tbConfigUart
FLAGS     ?= --binary --timing
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

SOURCES := $(wildcard src/*.sv) $(wildcard include/*.svh) $(wildcard test/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
+incdir+include
src/uartPkg.sv
src/loaderPkg.sv
src/uartRx.sv
src/loaderFsm.sv
src/dataByteDecoder.sv
src/wordAssembler.sv
src/configUart.sv
test/tbConfigUart.sv

// ==== src/configUart.sv ====
module configUart #(
    parameter uartPkg::baudCountT      COM_RATE       = 217,
    parameter loaderPkg::timeoutCountT TIMEOUT_CYCLES = 16776,
    parameter loaderPkg::loaderModeT   MODE           = loaderPkg::modeAuto
) (
    input  logic               CLK,
    input  logic               resetn,
    input  logic               Rx,
    output loaderPkg::cfgWordT WriteData,
    output logic               WriteStrobe,
    output logic               ComActive,
    output loaderPkg::cmdByteT Command
);
    import uartPkg::*;

    logic   frameStart;
    rxByteT rxByte;
    logic   byteValid;
    logic   dataValid;
    logic   hexMode;
    rxByteT dataByte;
    logic   dataByteValid;

    uartRx #(
        .COM_RATE(COM_RATE)
    ) rx_i (
        .CLK       (CLK),
        .resetn    (resetn),
        .Rx        (Rx),
        .frameStart(frameStart),
        .rxByte    (rxByte),
        .byteValid (byteValid)
    );

    // ComActive is the data phase itself
    loaderFsm #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
        .MODE          (MODE)
    ) loader_i (
        .CLK       (CLK),
        .resetn    (resetn),
        .frameStart(frameStart),
        .rxByte    (rxByte),
        .byteValid (byteValid),
        .dataValid (dataValid),
        .hexMode   (hexMode),
        .dataPhase (ComActive),
        .Command   (Command)
    );

    dataByteDecoder decoder_i (
        .CLK          (CLK),
        .resetn       (resetn),
        .rxByte       (rxByte),
        .dataValid    (dataValid),
        .hexMode      (hexMode),
        .dataPhase    (ComActive),
        .dataByte     (dataByte),
        .dataByteValid(dataByteValid)
    );

    wordAssembler assembler_i (
        .CLK          (CLK),
        .resetn       (resetn),
        .dataByte     (dataByte),
        .dataByteValid(dataByteValid),
        .dataPhase    (ComActive),
        .WriteData    (WriteData),
        .WriteStrobe  (WriteStrobe)
    );

endmodule

// ==== src/dataByteDecoder.sv ====
module dataByteDecoder (
    input  logic            CLK,
    input  logic            resetn,
    input  uartPkg::rxByteT rxByte,
    input  logic            dataValid,
    input  logic            hexMode,
    input  logic            dataPhase,
    output uartPkg::rxByteT dataByte,
    output logic            dataByteValid
);
    import uartPkg::*;

    typedef enum logic {
        highNibble,
        lowNibble
    } pairStateT;

    pairStateT  pairState;
    logic [4:0] nibble;   // bit 4 set for a non-hex character
    logic       hexOk;
    logic [3:0] highReg;

    // ASCII 0-9, A-F, a-f to a nibble
    function automatic logic [4:0] hexNibble(input rxByteT c);
        rxByteT v;
        if (c >= 8'h30 && c <= 8'h39) begin
            v = c - 8'h30;
        end else if (c >= 8'h41 && c <= 8'h46) begin
            v = c - 8'h37;
        end else if (c >= 8'h61 && c <= 8'h66) begin
            v = c - 8'h57;
        end else begin
            v = 8'h10;
        end
        return v[4:0];
    endfunction

    assign nibble = hexNibble(rxByte);
    assign hexOk  = !nibble[4];

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            pairState     <= highNibble;
            dataByteValid <= 1'b0;
        end else begin
            dataByteValid <= 1'b0;
            if (!dataPhase) begin
                pairState <= highNibble;
            end else if (dataValid) begin
                if (!hexMode) begin
                    dataByteValid <= 1'b1;
                end else if (hexOk) begin  // spaces and line ends just fall through
                    if (pairState == highNibble) begin
                        pairState <= lowNibble;
                    end else begin
                        pairState     <= highNibble;
                        dataByteValid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (dataValid) begin
            if (!hexMode) begin
                dataByte <= rxByte;
            end else if (hexOk && pairState == highNibble) begin
                highReg <= nibble[3:0];
            end else if (hexOk) begin
                dataByte <= {highReg, nibble[3:0]};
            end
        end
    end

endmodule

// ==== src/loaderFsm.sv ====
module loaderFsm #(
    parameter loaderPkg::timeoutCountT TIMEOUT_CYCLES = 16776,
    parameter loaderPkg::loaderModeT   MODE           = loaderPkg::modeAuto
) (
    input  logic               CLK,
    input  logic               resetn,
    input  logic               frameStart,
    input  uartPkg::rxByteT    rxByte,
    input  logic               byteValid,
    output logic               dataValid,
    output logic               hexMode,
    output logic               dataPhase,
    output loaderPkg::cmdByteT Command
);
    import loaderPkg::*;

    loaderStateT  state;
    logic [23:0]  idReg;
    cmdByteT      cmdReg;
    timeoutCountT timer;
    logic         timedOut;
    logic         headerOk;

    assign timedOut = (timer == '0);

    assign headerOk = (idReg == LOADER_ID) &&
                      (cmdReg[CMD_HEX_BIT-1:0] == CMD_WRITE_A ||
                       cmdReg[CMD_HEX_BIT-1:0] == CMD_WRITE_B);

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (frameStart) begin
                        state <= getId0;
                    end
                end
                evalCommand: begin
                    // always a single cycle, the timer cannot expire here
                    if (headerOk) begin
                        state <= getData;
                    end else begin
                        state <= idle;
                    end
                end
                getData: begin
                    if (timedOut) begin
                        state <= idle;  // line went quiet, load is over
                    end
                end
                default: begin  // header bytes
                    if (timedOut) begin
                        state <= idle;
                    end else if (byteValid) begin
                        state <= loaderStateT'(state + 1'b1);
                    end
                end
            endcase
        end
    end

    // ID bytes shift in from the right, 00 ends up on top
    always_ff @(posedge CLK) begin
        if (byteValid && state inside {getId0, getId1, getId2}) begin
            idReg <= {idReg[15:0], rxByte};
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            cmdReg <= '0;
        end else if (byteValid && state == getCommand) begin
            cmdReg <= rxByte;  // kept even if the header is rejected
        end
    end

    // inactivity timer, restarted by every start bit
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            timer <= TIMEOUT_CYCLES;
        end else if (state == idle || frameStart) begin
            timer <= TIMEOUT_CYCLES;
        end else if (!timedOut) begin
            timer <= timer - 1'b1;
        end
    end

    assign dataPhase = (state == getData);
    assign dataValid = byteValid && dataPhase;
    assign hexMode   = (MODE == modeHex) || ((MODE == modeAuto) && cmdReg[CMD_HEX_BIT]);
    assign Command   = cmdReg;

    evalOneCycle: assert property (@(posedge CLK) disable iff (!resetn)
        state == evalCommand |=> state != evalCommand);

endmodule

// ==== src/loaderPkg.sv ====
package loaderPkg;

    typedef logic [31:0] cfgWordT;       // one configuration word
    typedef logic [7:0]  cmdByteT;       // header command byte
    typedef logic [14:0] timeoutCountT;  // inactivity timer

    // header parser states, order matters since the header bytes step through them
    typedef enum logic [2:0] {
        idle,
        getId0,
        getId1,
        getId2,
        getCommand,
        evalCommand,
        getData
    } loaderStateT;

    // build mode, auto follows the command hex bit
    typedef enum logic [1:0] {
        modeAuto,
        modeHex,
        modeBin
    } loaderModeT;

    localparam logic [23:0] LOADER_ID = 24'h00AAFF;  // 00, AA, FF in arrival order

    localparam int CMD_HEX_BIT = 7;  // 1 selects ASCII-hex data

    // accepted values of the low command bits
    localparam logic [CMD_HEX_BIT-1:0] CMD_WRITE_A = 7'd1;
    localparam logic [CMD_HEX_BIT-1:0] CMD_WRITE_B = 7'd2;

endpackage

// ==== src/uartPkg.sv ====
package uartPkg;

    // one received character
    typedef logic [7:0] rxByteT;

    // clocks per bit, wide enough for slow baud rates on fast clocks
    typedef logic [11:0] baudCountT;

    typedef enum logic [1:0] {
        waitStart,   // line idle, looking for a falling edge
        delayStart,  // half a bit into the start bit
        dataBits,    // sampling the eight data bits
        stopBit      // waiting for the middle of the stop bit
    } rxStateT;

    localparam int FRAME_DATA_BITS = 8;  // 8N1

endpackage

// ==== src/uartRx.sv ====
module uartRx #(
    parameter uartPkg::baudCountT COM_RATE = 217
) (
    input  logic            CLK,
    input  logic            resetn,
    input  logic            Rx,
    output logic            frameStart,
    output uartPkg::rxByteT rxByte,
    output logic            byteValid
);
    import uartPkg::*;

    localparam int BIT_IDX_W = $clog2(FRAME_DATA_BITS);
    localparam logic [BIT_IDX_W-1:0] LAST_BIT = BIT_IDX_W'(FRAME_DATA_BITS - 1);

    rxStateT              rxState;
    baudCountT            baudCount;
    logic                 baudTick;
    logic                 rxSync;
    logic [BIT_IDX_W-1:0] bitIndex;
    rxByteT               shiftReg;

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxSync <= 1'b1;  // line idles high
        end else begin
            rxSync <= Rx;
        end
    end

    // baud tick generator, period COM_RATE + 1
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            baudCount <= COM_RATE >> 1;
            baudTick  <= 1'b0;
        end else if (rxState == waitStart) begin
            baudCount <= COM_RATE >> 1;  // first tick lands mid start bit
            baudTick  <= 1'b0;
        end else if (baudCount == '0) begin
            baudCount <= COM_RATE;
            baudTick  <= 1'b1;
        end else begin
            baudCount <= baudCount - 1'b1;
            baudTick  <= 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxState    <= waitStart;
            bitIndex   <= '0;
            frameStart <= 1'b0;
            byteValid  <= 1'b0;
        end else begin
            frameStart <= (rxState == waitStart) && !rxSync;
            byteValid  <= (rxState == stopBit) && baudTick;
            case (rxState)
                waitStart: begin
                    bitIndex <= '0;
                    if (!rxSync) begin
                        rxState <= delayStart;
                    end
                end
                delayStart: begin
                    if (baudTick) begin
                        rxState <= dataBits;
                    end
                end
                dataBits: begin
                    if (baudTick) begin
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == LAST_BIT) begin
                            rxState <= stopBit;
                        end
                    end
                end
                default: begin  // stopBit, level not checked
                    if (baudTick) begin
                        rxState <= waitStart;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (rxState == dataBits && baudTick) begin
            shiftReg <= {rxSync, shiftReg[FRAME_DATA_BITS-1:1]};  // LSB arrives first
        end
    end

    assign rxByte = shiftReg;  // holds until the next frame's first data bit

    singleByteValid: assert property (@(posedge CLK) disable iff (!resetn)
        byteValid |=> !byteValid);

endmodule

// ==== src/wordAssembler.sv ====
module wordAssembler (
    input  logic               CLK,
    input  logic               resetn,
    input  uartPkg::rxByteT    dataByte,
    input  logic               dataByteValid,
    input  logic               dataPhase,
    output loaderPkg::cfgWordT WriteData,
    output logic               WriteStrobe
);
    import uartPkg::*;
    import loaderPkg::*;

    typedef enum logic [1:0] {
        byte0,
        byte1,
        byte2,
        byte3
    } bytePosT;

    bytePosT bytePos;
    logic    dataPhaseQ;
    logic    phaseStart;

    assign phaseStart = dataPhase && !dataPhaseQ;

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            dataPhaseQ  <= 1'b0;
            bytePos     <= byte0;
            WriteData   <= '0;
            WriteStrobe <= 1'b0;
        end else begin
            dataPhaseQ  <= dataPhase;
            WriteStrobe <= dataByteValid && (bytePos == byte3);
            if (phaseStart) begin
                // drop whatever a timed out load left behind
                bytePos   <= byte0;
                WriteData <= '0;
            end else if (dataByteValid) begin
                bytePos   <= bytePosT'(bytePos + 1'b1);  // wraps after byte3
                // MSB first, the first byte ends up on top after four shifts
                WriteData <= {WriteData[$bits(cfgWordT)-$bits(rxByteT)-1:0], dataByte};
            end
        end
    end

    strobeAfterByte: assert property (@(posedge CLK) disable iff (!resetn)
        WriteStrobe |-> $past(dataByteValid));

endmodule

// ==== include/tbTasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// included inside the testbench module, which declares CLK, Rx, errCount and checkCount

// Galois LFSR, one step per random bit
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

task automatic randomByte(inout logic [31:0] state, output logic [7:0] value);
    for (int i = 0; i < 8; i++) begin
        state    = lfsrStep(state);
        value[i] = state[0];
    end
endtask

// 8N1 frame plus one idle bit, bit edges on the falling clock
task automatic sendByte(input logic [7:0] value, input int bitCycles);
    logic [10:0] frame;
    frame = {2'b11, value, 1'b0};
    @(negedge CLK);
    for (int i = 0; i < 11; i++) begin
        Rx <= frame[i];
        repeat (bitCycles) @(negedge CLK);
    end
endtask

task automatic checkWord(input string testName, input loaderPkg::cfgWordT expected,
                         input loaderPkg::cfgWordT actual);
    checkCount++;
    if (actual !== expected) begin
        errCount++;
        $display("ERR %s: expected %h, got %h", testName, expected, actual);
    end
endtask

task automatic checkCommand(input string testName, input loaderPkg::cmdByteT expected,
                            input loaderPkg::cmdByteT actual);
    checkCount++;
    if (actual !== expected) begin
        errCount++;
        $display("ERR %s: expected command %h, got %h", testName, expected, actual);
    end
endtask

task automatic checkLogic(input string testName, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
        errCount++;
        $display("ERR %s: expected %b, got %b", testName, expected, actual);
    end
endtask

`endif

// ==== test/tbConfigUart.sv ====
module tbConfigUart;
    import uartPkg::*;
    import loaderPkg::*;

    localparam int COM_RATE       = 8;
    localparam int TIMEOUT_CYCLES = 400;
    localparam int BIT_CYCLES     = COM_RATE + 1;
    localparam int FRAME_CYCLES   = 11 * BIT_CYCLES + 1;  // frame, idle bit, edge alignment
    localparam int TOTAL_FRAMES   = 94;                   // all frames of all tests
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_CYCLES
                                     + 6 * (TIMEOUT_CYCLES + 100) + 2000;

    logic    CLK;
    logic    resetn;
    logic    Rx;
    cfgWordT WriteData;
    logic    WriteStrobe;
    logic    ComActive;
    cmdByteT Command;

    int          errCount = 0;
    int          checkCount = 0;
    logic [31:0] lfsr = 32'h8e53;
    cfgWordT     gotWords[$];  // words seen on the write port
    logic        comActiveSeen;

    `include "tbTasks.svh"

    configUart #(
        .COM_RATE      (COM_RATE),
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
        .MODE          (loaderPkg::modeAuto)
    ) dut_i (
        .CLK        (CLK),
        .resetn     (resetn),
        .Rx         (Rx),
        .WriteData  (WriteData),
        .WriteStrobe(WriteStrobe),
        .ComActive  (ComActive),
        .Command    (Command)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // sees the values held over the cycle that this rising edge ends
    always @(posedge CLK) begin
        if (WriteStrobe) begin
            gotWords.push_back(WriteData);
        end
        if (ComActive) begin
            comActiveSeen = 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("watchdog expired after %0d cycles, a test hung", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    function automatic rxByteT hexChar(input logic [3:0] nib, input logic lower);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end else if (lower) begin
            return 8'h57 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    task automatic sendHeader(input rxByteT id1, input cmdByteT cmd);
        sendByte(8'h00, BIT_CYCLES);
        sendByte(id1, BIT_CYCLES);
        sendByte(8'hFF, BIT_CYCLES);
        sendByte(cmd, BIT_CYCLES);
    endtask

    // previous load has to time out before a new header means anything
    task automatic startTest();
        int n;
        n = 0;
        while (ComActive && n < TIMEOUT_CYCLES + 100) begin
            @(negedge CLK);
            n++;
        end
        if (ComActive) begin
            errCount++;
            $display("loader never left the data phase before the next test");
        end
        gotWords.delete();
        comActiveSeen = 1'b0;
    endtask

    task automatic waitWords(input string testName, input int count);
        int n;
        n = 0;
        while (gotWords.size() < count && n < 8 * BIT_CYCLES) begin
            @(negedge CLK);
            n++;
        end
        repeat (2) @(negedge CLK);  // catch a stray extra strobe
        if (gotWords.size() != count) begin
            errCount++;
            $display("%s: saw %0d write strobes where %0d were due", testName,
                     gotWords.size(), count);
        end
    endtask

    task automatic finishTest(input string testName, input int errBefore);
        $display("%s: done, %0d errors", testName, errCount - errBefore);
    endtask

    task automatic binaryLoad();
        string   name;
        int      errBefore;
        rxByteT  b;
        cfgWordT expected[2];
        name = "binary load";
        errBefore = errCount;
        startTest();
        sendHeader(8'hAA, 8'h01);
        for (int i = 0; i < 8; i++) begin
            randomByte(lfsr, b);
            expected[i / 4] = {expected[i / 4][23:0], b};  // MSB first
            sendByte(b, BIT_CYCLES);
        end
        waitWords(name, 2);
        for (int i = 0; i < 2 && i < gotWords.size(); i++) begin
            checkWord(name, expected[i], gotWords[i]);
        end
        checkCommand(name, 8'h01, Command);
        checkLogic(name, 1'b1, ComActive);
        finishTest(name, errBefore);
    endtask

    // two random words as hex text, optionally with separators after each pair
    task automatic hexLoad(input string name, input logic separate);
        int      errBefore;
        rxByteT  b;
        cfgWordT expected[2];
        errBefore = errCount;
        startTest();
        sendHeader(8'hAA, 8'h82);
        for (int w = 0; w < 2; w++) begin
            for (int i = 0; i < 4; i++) begin
                randomByte(lfsr, b);
                expected[w] = {expected[w][23:0], b};
            end
            for (int i = 7; i >= 0; i--) begin
                lfsr = lfsrStep(lfsr);  // one bit picks the letter case
                sendByte(hexChar(expected[w][i*4 +: 4], lfsr[0]), BIT_CYCLES);
                if (separate && i % 2 == 0) begin
                    sendByte(8'h20, BIT_CYCLES);
                    sendByte(8'h0A, BIT_CYCLES);
                end
            end
        end
        waitWords(name, 2);
        for (int i = 0; i < 2 && i < gotWords.size(); i++) begin
            checkWord(name, expected[i], gotWords[i]);
        end
        checkCommand(name, 8'h82, Command);
        finishTest(name, errBefore);
    endtask

    task automatic headerRejection();
        string name;
        int    errBefore;
        name = "header rejection";
        errBefore = errCount;
        startTest();
        sendHeader(8'h55, 8'h01);  // wrong second ID byte
        sendHeader(8'hAA, 8'h05);  // good ID, unknown command
        checkCommand(name, 8'h05, Command);
        // a whole word of data, seen as one more bad header by an idle loader
        sendByte(8'h12, BIT_CYCLES);
        sendByte(8'h34, BIT_CYCLES);
        sendByte(8'h56, BIT_CYCLES);
        sendByte(8'h78, BIT_CYCLES);
        repeat (4) @(negedge CLK);
        checkLogic(name, 1'b0, comActiveSeen);
        if (gotWords.size() != 0) begin
            errCount++;
            $display("%s: write strobe after a rejected header", name);
        end
        finishTest(name, errBefore);
    endtask

    task automatic loadTimeout();
        string   name;
        int      errBefore;
        rxByteT  b;
        cfgWordT expected;
        name = "timeout";
        errBefore = errCount;
        startTest();
        sendHeader(8'hAA, 8'h01);
        for (int i = 0; i < 2; i++) begin
            randomByte(lfsr, b);
            sendByte(b, BIT_CYCLES);
        end
        repeat (TIMEOUT_CYCLES + 50) @(negedge CLK);
        checkLogic(name, 1'b0, ComActive);
        gotWords.delete();
        sendHeader(8'hAA, 8'h01);
        for (int i = 0; i < 4; i++) begin
            randomByte(lfsr, b);
            expected = {expected[23:0], b};
            sendByte(b, BIT_CYCLES);
        end
        waitWords(name, 1);
        if (gotWords.size() > 0) begin
            checkWord(name, expected, gotWords[0]);
        end
        finishTest(name, errBefore);
    endtask

    initial begin
        resetn = 1'b0;
        Rx = 1'b1;
        comActiveSeen = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        resetn = 1'b1;
        checkLogic("reset", 1'b0, ComActive);
        checkLogic("reset", 1'b0, WriteStrobe);
        checkWord("reset", 32'h0000_0000, WriteData);
        checkCommand("reset", 8'h00, Command);
        binaryLoad();
        hexLoad("hex load", 1'b0);
        hexLoad("hex filtering", 1'b1);
        headerRejection();
        loadTimeout();
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
